/* logic/id_cfg.svh */
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath and register file geometry
`define ID_XLEN     32
`define ID_NREGS    32
`define ID_RADDR_W  5

// bubble marker pc
`define ID_NOP_PC   32'hFFFF_FFFF
// addi x0, x0, 0
`define ID_NOP_IR   32'h0000_0013

`endif

/* logic/id_pkg.sv */
`include "id_cfg.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]    word_t;
    typedef logic [`ID_RADDR_W-1:0] regaddr_t;

    // major opcodes, ir[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_AUIPC  = 7'b001_0111,
        OPC_STORE  = 7'b010_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_mode_e;

    typedef enum logic [1:0] {OP1_ZERO, OP1_RS1, OP1_IMM_U} op1_sel_e;

    typedef enum logic [2:0] {OP2_ZERO, OP2_RS2, OP2_IMM_I, OP2_IMM_S, OP2_PC} op2_sel_e;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_e;

    typedef enum logic [1:0] {MA_NONE, MA_LOAD, MA_STORE} ma_mode_e;

    typedef enum logic [1:0] {MA_BYTE, MA_HALF, MA_WORD} ma_size_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_e;

endpackage

/* logic/id_decode_if.sv */
interface id_decode_if import id_pkg::*; ();

    regaddr_t  rs1, rs2, rd;
    logic [2:0] f3;
    word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    logic      ra_used, rb_used;

    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    alu_mode_e alu_mode;
    pc_mode_e  pc_mode;
    ma_mode_e  ma_mode;
    ma_size_e  ma_size;
    wb_src_e   wb_src;
    logic      wb_valid;

    modport producer (
        output rs1, rs2, rd, f3, imm_i, imm_s, imm_b, imm_u, imm_j, ra_used, rb_used,
               op1_sel, op2_sel, alu_mode, pc_mode, ma_mode, ma_size, wb_src, wb_valid
    );

    // register reads and hazard check only need the sources
    modport operands (input rs1, rs2, ra_used, rb_used);

    modport issue (
        input rd, f3, imm_i, imm_s, imm_b, imm_u, imm_j,
              op1_sel, op2_sel, alu_mode, pc_mode, ma_mode, ma_size, wb_src, wb_valid
    );

endinterface

/* logic/id_decoder.sv */
module id_decoder import id_pkg::*; (
    input  word_t         ir_i,
    id_decode_if.producer dec_o
);

    opcode_e    opcode;
    logic [2:0] f3;
    logic       alt;      // funct7 bit 5 where it selects sub/sra
    alu_mode_e  alu_mode; // arithmetic mode from funct3

    assign opcode = opcode_e'(ir_i[6:0]);
    assign f3     = ir_i[14:12];
    assign alt    = ir_i[30] && (opcode == OPC_OP || f3 == 3'b101);

    assign dec_o.rs1 = ir_i[19:15];
    assign dec_o.rs2 = ir_i[24:20];
    assign dec_o.rd  = ir_i[11:7];
    assign dec_o.f3  = f3;

    // sign-extended immediates
    assign dec_o.imm_i = {{21{ir_i[31]}}, ir_i[30:20]};
    assign dec_o.imm_s = {{21{ir_i[31]}}, ir_i[30:25], ir_i[11:7]};
    assign dec_o.imm_b = {{20{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign dec_o.imm_u = {ir_i[31:12], 12'b0};
    assign dec_o.imm_j = {{12{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    always_comb begin
        unique case (f3)
            3'b000:  alu_mode = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_mode = ALU_SLL;
            3'b010:  alu_mode = ALU_SLT;
            3'b011:  alu_mode = ALU_SLTU;
            3'b100:  alu_mode = ALU_XOR;
            3'b101:  alu_mode = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_mode = ALU_OR;
            default: alu_mode = ALU_AND;
        endcase
    end

    always_comb begin
        // defaults describe a bubble
        dec_o.ra_used  = 1'b0;
        dec_o.rb_used  = 1'b0;
        dec_o.op1_sel  = OP1_ZERO;
        dec_o.op2_sel  = OP2_ZERO;
        dec_o.alu_mode = ALU_ADD;
        dec_o.pc_mode  = PC_NEXT;
        dec_o.ma_mode  = MA_NONE;
        dec_o.ma_size  = MA_WORD;
        dec_o.wb_src   = WB_ALU;
        dec_o.wb_valid = 1'b0;

        case (opcode)
            OPC_OP: begin
                dec_o.ra_used  = 1'b1;
                dec_o.rb_used  = 1'b1;
                dec_o.op1_sel  = OP1_RS1;
                dec_o.op2_sel  = OP2_RS2;
                dec_o.alu_mode = alu_mode;
                dec_o.wb_valid = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_o.ra_used  = 1'b1;
                dec_o.op1_sel  = OP1_RS1;
                dec_o.op2_sel  = OP2_IMM_I;
                dec_o.alu_mode = alu_mode;
                dec_o.wb_valid = 1'b1;
            end
            OPC_LUI: begin
                dec_o.op1_sel  = OP1_IMM_U; // imm + 0
                dec_o.wb_valid = 1'b1;
            end
            OPC_AUIPC: begin
                dec_o.op1_sel  = OP1_IMM_U;
                dec_o.op2_sel  = OP2_PC;
                dec_o.wb_valid = 1'b1;
            end
            OPC_JAL: begin
                dec_o.pc_mode  = PC_JUMP_REL;
                dec_o.wb_src   = WB_PC4;
                dec_o.wb_valid = 1'b1;
            end
            OPC_JALR: begin
                dec_o.ra_used  = 1'b1;
                dec_o.pc_mode  = PC_JUMP_ABS;
                dec_o.wb_src   = WB_PC4;
                dec_o.wb_valid = 1'b1;
            end
            OPC_BRANCH: begin
                dec_o.ra_used  = 1'b1;
                dec_o.rb_used  = 1'b1;
                dec_o.pc_mode  = PC_BRANCH;
            end
            OPC_LOAD, OPC_STORE: begin
                dec_o.ra_used  = 1'b1;
                dec_o.op1_sel  = OP1_RS1; // address = rs1 + offset
                dec_o.ma_size  = (f3[1:0] == 2'b00) ? MA_BYTE :
                                 (f3[1:0] == 2'b01) ? MA_HALF : MA_WORD;
                if (opcode == OPC_LOAD) begin
                    dec_o.op2_sel  = OP2_IMM_I;
                    dec_o.ma_mode  = MA_LOAD;
                    dec_o.wb_src   = WB_MEM;
                    dec_o.wb_valid = 1'b1;
                end else begin
                    dec_o.rb_used  = 1'b1;
                    dec_o.op2_sel  = OP2_IMM_S;
                    dec_o.ma_mode  = MA_STORE;
                end
            end
            default: ; // unknown opcode stays a bubble
        endcase
    end

endmodule

/* logic/id_regfile.sv */
`include "id_cfg.svh"

module id_regfile import id_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  regaddr_t rd1_addr_i,
    input  regaddr_t rd2_addr_i,
    output word_t    rd1_data_o,
    output word_t    rd2_data_o,
    input  regaddr_t wr_addr_i,
    input  word_t    wr_data_i,
    input  logic     wr_en_i
);

    word_t regs [`ID_NREGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin // x0 is read-only
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

/* logic/id_operand_unit.sv */
module id_operand_unit import id_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    id_decode_if.operands dec_i,
    input  regaddr_t ex_wb_addr_i,
    input  word_t    ex_wb_data_i,
    input  logic     ex_wb_valid_i,
    input  logic     ex_wb_ready_i,
    input  regaddr_t ma_wb_addr_i,
    input  word_t    ma_wb_data_i,
    input  logic     ma_wb_valid_i,
    input  logic     ma_wb_ready_i,
    input  regaddr_t wb_addr_i,
    input  word_t    wb_data_i,
    input  logic     wb_valid_i,
    output word_t    ra_o,
    output word_t    rb_o,
    output logic     hazard_o
);

    word_t rf_ra, rf_rb;

    id_regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd1_addr_i (dec_i.rs1),
        .rd2_addr_i (dec_i.rs2),
        .rd1_data_o (rf_ra),
        .rd2_data_o (rf_rb),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_valid_i)
    );

    // newest producer wins; x0 is never forwarded
    function automatic word_t bypass(input regaddr_t addr, input word_t rf_data);
        if (addr == '0)
            return '0;
        else if (ex_wb_valid_i && addr == ex_wb_addr_i)
            return ex_wb_data_i;
        else if (ma_wb_valid_i && addr == ma_wb_addr_i)
            return ma_wb_data_i;
        else if (wb_valid_i && addr == wb_addr_i)
            return wb_data_i;
        return rf_data;
    endfunction

    // result promised by ex or ma but not computed yet
    function automatic logic pending(input regaddr_t addr);
        return (ex_wb_valid_i && !ex_wb_ready_i && addr == ex_wb_addr_i) ||
               (ma_wb_valid_i && !ma_wb_ready_i && addr == ma_wb_addr_i);
    endfunction

    always_comb begin
        ra_o     = bypass(dec_i.rs1, rf_ra);
        rb_o     = bypass(dec_i.rs2, rf_rb);
        hazard_o = (dec_i.ra_used && pending(dec_i.rs1)) ||
                   (dec_i.rb_used && pending(dec_i.rs2));
    end

endmodule

/* logic/id_issue.sv */
`include "id_cfg.svh"

module id_issue import id_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  word_t     pc_i,
    input  word_t     ir_i,
    id_decode_if.issue dec_i,
    input  word_t     ra_i,
    input  word_t     rb_i,
    input  logic      hazard_i,
    output logic      ready_o,
    output logic      jmp_valid_o,
    output word_t     jmp_addr_o,
    output word_t     pc_o,
    output word_t     ir_o,
    output word_t     alu_op1_o,
    output word_t     alu_op2_o,
    output alu_mode_e alu_mode_o,
    output ma_mode_e  ma_mode_o,
    output ma_size_e  ma_size_o,
    output word_t     ma_data_o,
    output wb_src_e   wb_src_o,
    output word_t     wb_data_o,
    output logic      wb_valid_o
);

    word_t op1, op2;
    logic  cond; // branch taken before f3[0] inversion

    always_comb begin
        unique case (dec_i.op1_sel)
            OP1_RS1:   op1 = ra_i;
            OP1_IMM_U: op1 = dec_i.imm_u;
            default:   op1 = '0;
        endcase
        unique case (dec_i.op2_sel)
            OP2_RS2:   op2 = rb_i;
            OP2_IMM_I: op2 = dec_i.imm_i;
            OP2_IMM_S: op2 = dec_i.imm_s;
            OP2_PC:    op2 = pc_i;
            default:   op2 = '0;
        endcase
    end

    always_comb begin
        unique case (dec_i.f3[2:1])
            2'b00:   cond = (ra_i == rb_i);
            2'b10:   cond = ($signed(ra_i) < $signed(rb_i));
            2'b11:   cond = (ra_i < rb_i);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        unique case (dec_i.pc_mode)
            PC_JUMP_REL: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = pc_i + dec_i.imm_j;
            end
            PC_JUMP_ABS: begin
                jmp_valid_o = !hazard_i;            // target needs a settled ra
                jmp_addr_o  = ra_i + dec_i.imm_i;
            end
            PC_BRANCH: begin
                jmp_valid_o = (cond ^ dec_i.f3[0]) && !hazard_i;
                jmp_addr_o  = pc_i + dec_i.imm_b;
            end
            default: begin
                jmp_valid_o = 1'b0;
                jmp_addr_o  = '0;
            end
        endcase
    end

    assign ready_o = !hazard_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o       <= `ID_NOP_PC;
            ir_o       <= `ID_NOP_IR;
            alu_op1_o  <= '0;
            alu_op2_o  <= '0;
            alu_mode_o <= ALU_ADD;
            ma_mode_o  <= MA_NONE;
            ma_size_o  <= MA_WORD;
            ma_data_o  <= '0;
            wb_src_o   <= WB_ALU;
            wb_data_o  <= '0;
            wb_valid_o <= 1'b0;
        end else if (hazard_i) begin
            // bubble while a source is pending
            pc_o       <= `ID_NOP_PC;
            ir_o       <= `ID_NOP_IR;
            alu_op1_o  <= '0;
            alu_op2_o  <= '0;
            alu_mode_o <= ALU_ADD;
            ma_mode_o  <= MA_NONE;
            ma_size_o  <= MA_WORD;
            ma_data_o  <= '0;
            wb_src_o   <= WB_ALU;
            wb_data_o  <= '0;
            wb_valid_o <= 1'b0;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            alu_op1_o  <= op1;
            alu_op2_o  <= op2;
            alu_mode_o <= dec_i.alu_mode;
            ma_mode_o  <= dec_i.ma_mode;
            ma_size_o  <= dec_i.ma_size;
            ma_data_o  <= rb_i;               // store data
            wb_src_o   <= dec_i.wb_src;
            wb_data_o  <= pc_i + 32'd4;       // link value
            wb_valid_o <= dec_i.wb_valid && dec_i.rd != '0;
        end
    end

endmodule

/* logic/id_stage.sv */
`include "id_cfg.svh"

module id_stage import id_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [`ID_XLEN-1:0]    pc_i,
    input  logic [`ID_XLEN-1:0]    ir_i,
    input  logic [`ID_RADDR_W-1:0] ex_wb_addr_i,
    input  logic [`ID_XLEN-1:0]    ex_wb_data_i,
    input  logic                   ex_wb_valid_i,
    input  logic                   ex_wb_ready_i,
    input  logic [`ID_RADDR_W-1:0] ma_wb_addr_i,
    input  logic [`ID_XLEN-1:0]    ma_wb_data_i,
    input  logic                   ma_wb_valid_i,
    input  logic                   ma_wb_ready_i,
    input  logic [`ID_RADDR_W-1:0] wb_addr_i,
    input  logic [`ID_XLEN-1:0]    wb_data_i,
    input  logic                   wb_valid_i,
    output logic                   ready_o,
    output logic                   jmp_valid_o,
    output logic [`ID_XLEN-1:0]    jmp_addr_o,
    output logic [`ID_XLEN-1:0]    pc_o,
    output logic [`ID_XLEN-1:0]    ir_o,
    output logic [`ID_XLEN-1:0]    alu_op1_o,
    output logic [`ID_XLEN-1:0]    alu_op2_o,
    output alu_mode_e              alu_mode_o,
    output ma_mode_e               ma_mode_o,
    output ma_size_e               ma_size_o,
    output logic [`ID_XLEN-1:0]    ma_data_o,
    output wb_src_e                wb_src_o,
    output logic [`ID_XLEN-1:0]    wb_data_o,
    output logic                   wb_valid_o
);

    word_t ra, rb; // bypassed source values
    logic  hazard;

    id_decode_if dec_if ();

    id_decoder u_decoder (
        .ir_i  (ir_i),
        .dec_o (dec_if.producer)
    );

    id_operand_unit u_operands (
        .clk_i, .arst_n_i,
        .dec_i (dec_if.operands),
        .ex_wb_addr_i, .ex_wb_data_i, .ex_wb_valid_i, .ex_wb_ready_i,
        .ma_wb_addr_i, .ma_wb_data_i, .ma_wb_valid_i, .ma_wb_ready_i,
        .wb_addr_i, .wb_data_i, .wb_valid_i,
        .ra_o     (ra),
        .rb_o     (rb),
        .hazard_o (hazard)
    );

    id_issue u_issue (
        .clk_i, .arst_n_i, .pc_i, .ir_i,
        .dec_i    (dec_if.issue),
        .ra_i     (ra),
        .rb_i     (rb),
        .hazard_i (hazard),
        .ready_o, .jmp_valid_o, .jmp_addr_o,
        .pc_o, .ir_o, .alu_op1_o, .alu_op2_o, .alu_mode_o,
        .ma_mode_o, .ma_size_o, .ma_data_o, .wb_src_o, .wb_data_o, .wb_valid_o
    );

endmodule

/* sim/id_stage_chk.sv */
`include "id_cfg.svh"

module id_stage_chk import id_pkg::*; (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input logic [`ID_XLEN-1:0]    ir_i,
    input logic [`ID_RADDR_W-1:0] ex_wb_addr_i,
    input logic                   ex_wb_valid_i,
    input logic                   ex_wb_ready_i,
    input logic [`ID_RADDR_W-1:0] ma_wb_addr_i,
    input logic                   ma_wb_valid_i,
    input logic                   ma_wb_ready_i,
    input logic                   ready_i,
    input logic                   jmp_valid_i,
    input logic [`ID_XLEN-1:0]    out_pc_i,
    input logic                   out_wb_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    opcode_e                opcode;
    logic [`ID_RADDR_W-1:0] rs1, rs2;
    logic                   rs1_read, rs2_read;
    logic                   ex_pending, ma_pending;
    logic                   stall;
    int                     failures = 0;

    assign opcode = opcode_e'(ir_i[6:0]);
    assign rs1    = ir_i[19:15];
    assign rs2    = ir_i[24:20];

    // source use by instruction format
    assign rs1_read = opcode inside {OPC_OP, OPC_OP_IMM, OPC_JALR,
                                     OPC_BRANCH, OPC_LOAD, OPC_STORE};
    assign rs2_read = opcode inside {OPC_OP, OPC_BRANCH, OPC_STORE};

    assign ex_pending = ex_wb_valid_i && !ex_wb_ready_i;
    assign ma_pending = ma_wb_valid_i && !ma_wb_ready_i;

    // expected stall straight from the instruction and the later stages
    assign stall = (rs1_read && ((ex_pending && rs1 == ex_wb_addr_i) ||
                                 (ma_pending && rs1 == ma_wb_addr_i))) ||
                   (rs2_read && ((ex_pending && rs2 == ex_wb_addr_i) ||
                                 (ma_pending && rs2 == ma_wb_addr_i)));

    // a stalled cycle leaves a bubble in the output register
    bubble_after_hazard: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall |=> (out_pc_i == `ID_NOP_PC && !out_wb_valid_i))
        else begin
            $error("no bubble after a hazard cycle");
            failures++;
        end

    ready_tracks_hazard: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_i == !stall)
        else begin
            $error("ready_o disagrees with the hazard condition");
            failures++;
        end

    // only jal, jalr and branches redirect the pc
    jump_needs_jump_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        jmp_valid_i |-> (opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH}))
        else begin
            $error("jmp_valid_o high for a sequential instruction");
            failures++;
        end

endmodule

bind id_stage id_stage_chk u_chk (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .ir_i           (ir_i),
    .ex_wb_addr_i   (ex_wb_addr_i),
    .ex_wb_valid_i  (ex_wb_valid_i),
    .ex_wb_ready_i  (ex_wb_ready_i),
    .ma_wb_addr_i   (ma_wb_addr_i),
    .ma_wb_valid_i  (ma_wb_valid_i),
    .ma_wb_ready_i  (ma_wb_ready_i),
    .ready_i        (ready_o),
    .jmp_valid_i    (jmp_valid_o),
    .out_pc_i       (pc_o),
    .out_wb_valid_i (wb_valid_o)
);

/* sim/tb_id_stage.sv */
`include "id_cfg.svh"

module tb_id_stage import id_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 6;

    logic      clk_i, arst_n_i;
    word_t     pc_i, ir_i;
    regaddr_t  ex_wb_addr_i, ma_wb_addr_i, wb_addr_i;
    word_t     ex_wb_data_i, ma_wb_data_i, wb_data_i;
    logic      ex_wb_valid_i, ex_wb_ready_i, ma_wb_valid_i, ma_wb_ready_i, wb_valid_i;
    logic      ready_o, jmp_valid_o, wb_valid_o;
    word_t     jmp_addr_o, pc_o, ir_o, alu_op1_o, alu_op2_o, ma_data_o, wb_data_o;
    alu_mode_e alu_mode_o;
    ma_mode_e  ma_mode_o;
    ma_size_e  ma_size_o;
    wb_src_e   wb_src_o;

    int    errors = 0;
    int    checks = 0;
    int    seed   = 1819;
    word_t rv [16]; // values written to x0..x15

    id_stage DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // instruction encoders
    function automatic word_t r_type(logic [6:0] f7, regaddr_t rs2, regaddr_t rs1,
                                     logic [2:0] f3, regaddr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, regaddr_t rs1, logic [2:0] f3,
                                     regaddr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, regaddr_t rs2, regaddr_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, regaddr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, regaddr_t rs2, regaddr_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, regaddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic expect_eq(input string what, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-22s %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic idle_stages();
        ex_wb_valid_i = 1'b0;
        ex_wb_ready_i = 1'b1;
        ma_wb_valid_i = 1'b0;
        ma_wb_ready_i = 1'b1;
        wb_valid_i    = 1'b0;
    endtask

    // drive on the falling edge only
    task automatic present(input word_t pc, input word_t ir);
        @(negedge clk_i);
        pc_i = pc;
        ir_i = ir;
    endtask

    // present and wait for the output register
    task automatic issue(input word_t pc, input word_t ir);
        present(pc, ir);
        @(negedge clk_i);
    endtask

    task automatic write_reg(input regaddr_t addr, input word_t data);
        @(negedge clk_i);
        wb_addr_i  = addr;
        wb_data_i  = data;
        wb_valid_i = 1'b1;
        @(negedge clk_i);
        wb_valid_i = 1'b0;
        if (addr != 0)
            rv[addr] = data;
    endtask

    task automatic check_reset();
        int e0;
        e0 = errors;
        arst_n_i = 1'b0;
        repeat (8) @(negedge clk_i);
        expect_eq("pc_o", `ID_NOP_PC, pc_o);
        expect_eq("ir_o", `ID_NOP_IR, ir_o);
        expect_eq("wb_valid_o", 0, wb_valid_o);
        repeat (8) @(negedge clk_i); // 16 cycles in reset
        arst_n_i = 1'b1;
        #1;
        expect_eq("pc_o", `ID_NOP_PC, pc_o);
        expect_eq("ir_o", `ID_NOP_IR, ir_o);
        expect_eq("ready_o", 1, ready_o);
        @(negedge clk_i);
        expect_eq("wb_valid_o", 0, wb_valid_o); // rd = x0
        report_test("reset", e0);
    endtask

    task automatic alu_issue(input word_t ir, input word_t op1, input word_t op2,
                             input alu_mode_e mode);
        issue(32'h0000_1000, ir);
        expect_eq("alu_op1_o", op1, alu_op1_o);
        expect_eq("alu_op2_o", op2, alu_op2_o);
        expect_eq("alu_mode_o", mode, alu_mode_o);
        expect_eq("wb_src_o", WB_ALU, wb_src_o);
        expect_eq("wb_valid_o", 1, wb_valid_o);
    endtask

    task automatic alu_from_registers();
        int e0;
        e0 = errors;
        idle_stages();
        for (int i = 1; i <= 4; i++)
            write_reg(regaddr_t'(i), $random(seed));
        write_reg(0, 32'hDEAD_BEEF);                     // dropped
        alu_issue(r_type(7'h00, 2, 1, 3'b000, 5), rv[1], rv[2], ALU_ADD);
        alu_issue(r_type(7'h20, 4, 3, 3'b000, 6), rv[3], rv[4], ALU_SUB);
        alu_issue(r_type(7'h00, 3, 2, 3'b100, 7), rv[2], rv[3], ALU_XOR);
        alu_issue(r_type(7'h20, 1, 4, 3'b101, 8), rv[4], rv[1], ALU_SRA);
        alu_issue(r_type(7'h00, 1, 0, 3'b000, 9), 0, rv[1], ALU_ADD); // x0 reads zero
        report_test("register_alu", e0);
    endtask

    task automatic immediate_operands();
        int e0;
        int imm_i;
        int imm_s;
        e0    = errors;
        imm_i = -5;
        imm_s = -300;
        idle_stages();
        issue(32'h0000_2000, i_type(imm_i[11:0], 1, 3'b000, 5, 7'b0010011)); // addi
        expect_eq("alu_op1_o", rv[1], alu_op1_o);
        expect_eq("alu_op2_o", word_t'(imm_i), alu_op2_o);
        issue(32'h0000_2004, s_type(imm_s[11:0], 2, 1, 3'b010));             // sw
        expect_eq("alu_op1_o", rv[1], alu_op1_o);
        expect_eq("alu_op2_o", word_t'(imm_s), alu_op2_o);
        expect_eq("ma_mode_o", MA_STORE, ma_mode_o);
        expect_eq("ma_size_o", MA_WORD, ma_size_o);
        expect_eq("ma_data_o", rv[2], ma_data_o);
        expect_eq("wb_valid_o", 0, wb_valid_o);
        issue(32'h0000_2008, u_type(20'hABCDE, 5, 7'b0110111));        // lui
        expect_eq("alu_op1_o", {20'hABCDE, 12'h000}, alu_op1_o);
        expect_eq("alu_op2_o", 0, alu_op2_o);
        issue(32'h0000_200C, u_type(20'h12345, 6, 7'b0010111));        // auipc
        expect_eq("alu_op1_o", {20'h12345, 12'h000}, alu_op1_o);
        expect_eq("alu_op2_o", 32'h0000_200C, alu_op2_o);
        report_test("immediates", e0);
    endtask

    task automatic bypass_priority();
        int    e0;
        word_t a, b, c, d;
        e0 = errors;
        a  = $random(seed);
        b  = $random(seed);
        c  = $random(seed);
        d  = $random(seed);
        present(32'h0000_3000, r_type(7'h00, 0, 1, 3'b000, 5)); // add x5, x1, x0
        ex_wb_addr_i  = 1;
        ex_wb_data_i  = a;
        ex_wb_valid_i = 1'b1;
        ma_wb_addr_i  = 1;
        ma_wb_data_i  = b;
        ma_wb_valid_i = 1'b1;
        wb_addr_i     = 1;
        wb_data_i     = c;
        wb_valid_i    = 1'b1;
        @(negedge clk_i);
        expect_eq("alu_op1_o", a, alu_op1_o);
        ex_wb_valid_i = 1'b0;
        @(negedge clk_i);
        expect_eq("alu_op1_o", b, alu_op1_o);
        ma_wb_valid_i = 1'b0;
        wb_data_i     = d; // x1 already holds c
        @(negedge clk_i);
        expect_eq("alu_op1_o", d, alu_op1_o);
        idle_stages();
        rv[1] = d; // wb also wrote x1
        report_test("bypass", e0);
    endtask

    task automatic hazard_stall();
        int    e0;
        int    waited;
        word_t d;
        e0 = errors;
        d  = $random(seed);
        present(32'h0000_4000, r_type(7'h00, 2, 1, 3'b000, 5)); // add x5, x1, x2
        ex_wb_addr_i  = 2;
        ex_wb_data_i  = d;
        ex_wb_valid_i = 1'b1;
        ex_wb_ready_i = 1'b0;
        #1;
        expect_eq("ready_o", 0, ready_o);
        repeat (2) begin
            @(negedge clk_i);
            expect_eq("pc_o", `ID_NOP_PC, pc_o);
            expect_eq("wb_valid_o", 0, wb_valid_o);
        end
        ex_wb_ready_i = 1'b1;
        waited = 0;
        #1;
        while (!ready_o && waited < 10) begin
            @(negedge clk_i);
            waited++;
        end
        if (!ready_o) begin
            $display("ready_o did not rise after the ex result became ready");
            errors++;
        end
        @(negedge clk_i);
        expect_eq("pc_o", 32'h0000_4000, pc_o);
        expect_eq("alu_op1_o", rv[1], alu_op1_o);
        expect_eq("alu_op2_o", d, alu_op2_o);
        expect_eq("wb_valid_o", 1, wb_valid_o);
        // upstream moves on right away
        pc_i = 32'h0000_4004;
        ir_i = `ID_NOP_IR;
        idle_stages();
        @(negedge clk_i);
        expect_eq("pc_o", 32'h0000_4004, pc_o);
        report_test("hazard_stall", e0);
    endtask

    task automatic branch_check(input logic [2:0] f3, input regaddr_t rs1,
                                input regaddr_t rs2, input logic taken, input int imm);
        present(32'h0000_6000, b_type(imm[12:0], rs2, rs1, f3));
        #1;
        expect_eq("jmp_valid_o", taken, jmp_valid_o);
        expect_eq("jmp_addr_o", 32'h0000_6000 + word_t'(imm), jmp_addr_o);
    endtask

    task automatic jumps_and_branches();
        int e0;
        int imm_j;
        e0    = errors;
        imm_j = -1024;
        idle_stages();
        present(32'h0000_5000, j_type(imm_j[20:0], 1));                // jal x1
        #1;
        expect_eq("jmp_valid_o", 1, jmp_valid_o);
        expect_eq("jmp_addr_o", 32'h0000_5000 + word_t'(imm_j), jmp_addr_o);
        present(32'h0000_5004, i_type(12'h015, 2, 3'b000, 1, 7'b1100111)); // jalr x1, 21(x2)
        expect_eq("wb_src_o", WB_PC4, wb_src_o);           // jal now in the output register
        expect_eq("wb_data_o", 32'h0000_5004, wb_data_o);
        #1;
        expect_eq("jmp_valid_o", 1, jmp_valid_o);
        expect_eq("jmp_addr_o", rv[2] + 32'd21, jmp_addr_o); // odd target kept
        @(negedge clk_i);
        ex_wb_addr_i  = 2;
        ex_wb_valid_i = 1'b1;
        ex_wb_ready_i = 1'b0;
        #1;
        expect_eq("jmp_valid_o", 0, jmp_valid_o);
        expect_eq("ready_o", 0, ready_o);
        @(negedge clk_i);
        idle_stages();
        write_reg(10, -3);
        write_reg(11, 5);
        write_reg(12, 5);
        branch_check(3'b000, 11, 12, 1'b1, 16);  // beq 5 == 5
        branch_check(3'b001, 11, 12, 1'b0, -16); // bne
        branch_check(3'b100, 10, 11, 1'b1, 64);  // blt -3 < 5
        branch_check(3'b111, 10, 11, 1'b1, 8);   // bgeu, big unsigned
        branch_check(3'b111, 11, 10, 1'b0, -32);
        report_test("jumps_branches", e0);
    endtask

    initial begin
        arst_n_i     = 1'b0;
        pc_i         = '0;
        ir_i         = `ID_NOP_IR;
        ex_wb_addr_i = '0;
        ex_wb_data_i = '0;
        ma_wb_addr_i = '0;
        ma_wb_data_i = '0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        idle_stages();
        check_reset();
        alu_from_registers();
        immediate_operands();
        bypass_priority();
        hazard_stall();
        jumps_and_branches();
        if (DUT.u_chk.failures != 0) begin
            $display("bound checker reported %0d assertion failures", DUT.u_chk.failures);
            errors++;
        end
        $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
logic/id_pkg.sv
logic/id_decode_if.sv
logic/id_decoder.sv
logic/id_regfile.sv
logic/id_operand_unit.sv
logic/id_issue.sv
logic/id_stage.sv
sim/id_stage_chk.sv
sim/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/id_pkg.sv
      - logic/id_decode_if.sv
      - logic/id_decoder.sv
      - logic/id_regfile.sv
      - logic/id_operand_unit.sv
      - logic/id_issue.sv
      - logic/id_stage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/id_stage_chk.sv
      - sim/tb_id_stage.sv
